// File: tb.f
rtl/imul_pkg.sv
rtl/imul_ctrl.sv
rtl/imul_dpath.sv
rtl/imul_var_latency.sv
verification/imul_tb.sv

// File: Bender.yml
package:
  name: imul_var_latency

sources:
  - files:
      - rtl/imul_pkg.sv
      - rtl/imul_ctrl.sv
      - rtl/imul_dpath.sv
      - rtl/imul_var_latency.sv
  - target: test
    files:
      - verification/imul_tb.sv

// File: verification/imul_tb.sv
// ----------------------------------------
// Testbench for the variable latency multiplier
// Clock, reset and LFSR stimulus with idle gaps
// Queue model of the low product half
// Back-pressure, ordering and count checks
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imul_tb;

  import imul_pkg::*;

  localparam int          NUM_RANDOM   = 200;
  localparam int          TIMEOUT      = 200;
  localparam int          DRAIN_CYCLES = 40;
  localparam logic [31:0] SEED         = 32'hf1c3;

  logic       clk;
  logic       rst_n;
  imul_req_t  req_msg;
  logic       req_val;
  logic       req_rdy;
  imul_resp_t resp_msg;
  logic       resp_val;
  logic       resp_rdy;

  // Operand lists and the model's expected responses
  logic [IMUL_WIDTH-1:0] a_list[$];
  logic [IMUL_WIDTH-1:0] b_list[$];
  imul_resp_t            expected_q[$];

  logic [31:0] lfsr;
  logic        stop_run;
  int          value_errors;
  int          timeout_errors;
  int          count_errors;
  int          accepted;
  int          responses;

  imul_var_latency i_imul_var_latency
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #4 clk = ~clk;

  // ----------------------------------------
  // Random numbers and checks
  // ----------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_resp(input string name, input imul_resp_t got, input imul_resp_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got.result, exp.result, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  // Falling edge polls, a high flag means a transfer on the next rising edge
  task automatic wait_for_handshake(input logic on_resp, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok && !stop_run; n++)
    begin
      @(negedge clk);
      ok = on_resp ? resp_val : req_rdy;
    end
    if (!ok && !stop_run)
    begin
      timeout_errors++;
      stop_run = 1'b1;
      $display("Timeout: %s never went high within %0d cycles",
               on_resp ? "resp_val" : "req_rdy", TIMEOUT);
    end
  endtask

  // Sink stays ready with no request outstanding, any response is one too many
  task automatic watch_for_extra_responses();
    int n;
    resp_rdy = 1'b1;
    for (n = 0; n < DRAIN_CYCLES; n++)
    begin
      @(negedge clk);
      if (resp_val)
        responses++;
    end
  endtask

  // ----------------------------------------
  // Stimulus, source and sink
  // ----------------------------------------

  task automatic add_case(input logic [31:0] a, input logic [31:0] b);
    a_list.push_back(a);
    b_list.push_back(b);
  endtask

  task automatic build_cases();
    int          i;
    logic [31:0] a;
    logic [31:0] b;
    // All four sign combinations, then wrapping squares
    add_case(32'd3, 32'd5);
    add_case(32'hffff_fffd, 32'd5);
    add_case(32'd3, 32'hffff_fffb);
    add_case(32'hffff_fffd, 32'hffff_fffb);
    add_case(32'h8000_0001, 32'h8000_0001);
    add_case(32'hffff_ffff, 32'hffff_ffff);
    add_case(32'h7fff_ffff, 32'h7fff_ffff);
    for (i = 0; i < NUM_RANDOM; i++)
    begin
      rand_bits(32, a);
      rand_bits(32, b);
      add_case(a, b);
    end
    // Zero multiplier skips straight to done
    add_case(a, 32'd0);
    add_case(a, 32'h8000_0000);
    for (i = 0; i < 4; i++)
    begin
      rand_bits(32, a);
      rand_bits(5, b);
      add_case(a, 32'd1 << b);
      rand_bits(32, b);
      add_case(a & 32'hffff_0000, b);
      add_case(a, b & 32'h0000_00ff);
    end
  endtask

  task automatic run_source();
    int                      i;
    logic [31:0]             gap;
    logic                    ok;
    logic [2*IMUL_WIDTH-1:0] prod;
    imul_resp_t              exp;
    for (i = 0; i < a_list.size() && !stop_run; i++)
    begin
      rand_bits(2, gap);
      repeat (gap) step_cycle();
      req_msg.a = a_list[i];
      req_msg.b = b_list[i];
      req_val   = 1'b1;
      wait_for_handshake(1'b0, ok);
      if (ok)
      begin
        // Model keeps only the low half of the full product
        prod       = a_list[i] * b_list[i];
        exp.result = prod[IMUL_WIDTH-1:0];
        expected_q.push_back(exp);
        accepted++;
        step_cycle();
      end
      req_val = 1'b0;
    end
  endtask

  task automatic run_sink(input int total);
    int          n;
    logic [31:0] stall;
    logic        ok;
    imul_resp_t  held;
    for (n = 0; n < total && !stop_run; n++)
    begin
      wait_for_handshake(1'b1, ok);
      if (ok)
      begin
        held = resp_msg;
        rand_bits(4, stall);
        // Stalled response must hold, and no request may be taken
        repeat (stall % 15)
        begin
          @(negedge clk);
          check_resp("resp_msg", resp_msg, held);
          check_bit("resp_val", resp_val, 1'b1);
          check_bit("req_rdy", req_rdy, 1'b0);
        end
        step_cycle();
        resp_rdy = 1'b1;
        @(negedge clk);
        if (expected_q.size() == 0)
        begin
          count_errors++;
          $display("A response arrived with no request outstanding");
        end
        else
          check_resp("resp_msg", resp_msg, expected_q.pop_front());
        responses++;
        step_cycle();
        resp_rdy = 1'b0;
      end
    end
  endtask

  initial
  begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    lfsr     = SEED;
    stop_run = 1'b0;
    build_cases();
    repeat (3) step_cycle();
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("resp_val", resp_val, 1'b0);
    check_bit("req_rdy", req_rdy, 1'b1);
    step_cycle();
    fork
      run_source();
      run_sink(a_list.size());
    join
    if (!stop_run)
      watch_for_extra_responses();
    if (!stop_run && responses != accepted)
    begin
      count_errors++;
      $display("Sent %0d requests, %0d accepted, %0d responses", a_list.size(),
               accepted, responses);
    end
    $display("Errors: %0d value, %0d timeout, %0d count", value_errors, timeout_errors,
             count_errors);
    if (value_errors + timeout_errors + count_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/imul_var_latency.sv
// ----------------------------------------
// Variable latency multiplier top level
// Control unit and datapath joined
// val/rdy request and response ports
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imul_var_latency
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Request side
  input  imul_pkg::imul_req_t  req_msg,
  input  logic                 req_val,
  output logic                 req_rdy,

  // Response side
  output imul_pkg::imul_resp_t resp_msg,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  import imul_pkg::*;

  // Control unit to datapath
  imul_ctrl_t   ctrl;

  // Datapath back to control unit
  imul_status_t status;

  // Handshakes and sequencing
  imul_ctrl i_imul_ctrl
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .status   (status),
    .ctrl     (ctrl)
  );

  // Shift-and-add engine, response read from its result register
  imul_dpath i_imul_dpath
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_msg  (req_msg),
    .ctrl     (ctrl),
    .status   (status),
    .resp_msg (resp_msg)
  );

endmodule

`default_nettype wire

// File: rtl/imul_dpath.sv
// ----------------------------------------
// Multiplier datapath
// Multiplicand, multiplier and result registers
// Left and right shifters, truncating adder
// Status flags for the control unit
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imul_dpath
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  imul_pkg::imul_req_t    req_msg,
  input  imul_pkg::imul_ctrl_t   ctrl,
  output imul_pkg::imul_status_t status,
  output imul_pkg::imul_resp_t   resp_msg
);

  import imul_pkg::*;

  // Registers
  logic [IMUL_WIDTH-1:0] a_reg;
  logic [IMUL_WIDTH-1:0] b_reg;
  logic [IMUL_WIDTH-1:0] result_reg;

  // Register inputs
  logic [IMUL_WIDTH-1:0] a_next;
  logic [IMUL_WIDTH-1:0] b_next;
  logic [IMUL_WIDTH-1:0] result_next;

  // Shifter and adder outputs
  logic [IMUL_WIDTH-1:0] a_shl;
  logic [IMUL_WIDTH-1:0] b_shr;
  logic [IMUL_WIDTH-1:0] sum;
  logic [IMUL_WIDTH-1:0] add_out;

  // ----------------------------------------
  // Shifters and adder
  // ----------------------------------------

  // Multiplicand moves up one bit per iteration
  assign a_shl = a_reg << 1;

  // Multiplier moves down, lsb always holds the current bit
  assign b_shr = b_reg >> 1;

  // Carry out of bit 31 dropped, only the low half is kept
  assign sum = result_reg + a_reg;

  assign add_out = (ctrl.add_sel == ADD_SUM) ? sum : result_reg;

  // ----------------------------------------
  // Register input muxes
  // ----------------------------------------

  assign a_next      = (ctrl.a_sel == SEL_SHIFT) ? a_shl : req_msg.a;
  assign b_next      = (ctrl.b_sel == SEL_SHIFT) ? b_shr : req_msg.b;
  assign result_next = (ctrl.result_sel == RES_NEXT) ? add_out : '0;

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (ctrl.a_en)
      a_reg <= a_next;
  end

  // Multiplier register runs every cycle
  // zero stays zero once shifted out
  always_ff @(posedge clk)
  begin
    b_reg <= b_next;
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.result_en)
      result_reg <= result_next;
  end

  // ----------------------------------------
  // Status and response
  // ----------------------------------------

  assign status.b_lsb  = b_reg[0];
  assign status.b_zero = (b_reg == '0);

  assign resp_msg.result = result_reg;

  // Flags steer the FSM once an operand pair has been taken
  a_status_known: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl.b_sel == SEL_SHIFT) |-> !$isunknown(status))
    else $error("status flags unknown during calculation");

endmodule

`default_nettype wire

// File: rtl/imul_ctrl.sv
// ----------------------------------------
// Multiplier control unit
// Three-state FSM for the val/rdy handshakes
// Decodes state and status into datapath selects
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imul_ctrl
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_val,
  output logic                  req_rdy,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  input  imul_pkg::imul_status_t status,
  output imul_pkg::imul_ctrl_t   ctrl
);

  import imul_pkg::*;

  imul_state_e state;
  imul_state_e state_next;

  // ----------------------------------------
  // State register
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_next;
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb
  begin
    state_next = state;
    case (state)
      // Leave on a request transfer
      ST_IDLE:
      begin
        if (req_val)
          state_next = ST_CALC;
      end
      // Last iteration once no multiplier bits remain
      ST_CALC:
      begin
        if (status.b_zero)
          state_next = ST_DONE;
      end
      // Wait for the response transfer
      ST_DONE:
      begin
        if (resp_rdy)
          state_next = ST_IDLE;
      end
      default:
        state_next = ST_IDLE;
    endcase
  end

  // ----------------------------------------
  // Output decode
  // ----------------------------------------

  always_comb
  begin
    req_rdy         = 1'b0;
    resp_val        = 1'b0;
    ctrl.a_sel      = SEL_SHIFT;
    ctrl.b_sel      = SEL_SHIFT;
    ctrl.result_sel = RES_NEXT;
    ctrl.add_sel    = ADD_PASS;
    ctrl.a_en       = 1'b0;
    ctrl.result_en  = 1'b0;
    case (state)
      ST_IDLE:
      begin
        req_rdy         = 1'b1;
        // Operands follow the request bus, a and result latch on transfer
        ctrl.a_sel      = SEL_LOAD;
        ctrl.b_sel      = SEL_LOAD;
        ctrl.result_sel = RES_ZERO;
        ctrl.a_en       = req_val;
        ctrl.result_en  = req_val;
      end
      ST_CALC:
      begin
        // Accumulate only when the current multiplier bit is set
        ctrl.add_sel   = status.b_lsb ? ADD_SUM : ADD_PASS;
        ctrl.a_en      = 1'b1;
        ctrl.result_en = 1'b1;
      end
      ST_DONE:
        resp_val = 1'b1;
      default:
        req_rdy = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Never accept a new request while a response is pending
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // Response stays offered until the sink takes it
  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_val && !resp_rdy |=> resp_val)
    else $error("resp_val dropped without resp_rdy");

endmodule

`default_nettype wire

// File: rtl/imul_pkg.sv
// ----------------------------------------
// Shared types for the iterative multiplier
// Operand width constant
// Request, response, control and status structs
// Datapath select encodings
// Control FSM state encoding
// ----------------------------------------

`default_nettype none

package imul_pkg;

  // Operand and result width
  localparam int IMUL_WIDTH = 32;

  // Operand register input selects
  localparam logic SEL_LOAD  = 1'b0;
  localparam logic SEL_SHIFT = 1'b1;

  // Result register input selects
  localparam logic RES_ZERO = 1'b0;
  localparam logic RES_NEXT = 1'b1;

  // Accumulate mux selects
  localparam logic ADD_PASS = 1'b0;
  localparam logic ADD_SUM  = 1'b1;

  // Request message, multiplicand in the upper half
  typedef struct packed {
    logic [IMUL_WIDTH-1:0] a;
    logic [IMUL_WIDTH-1:0] b;
  } imul_req_t;

  // Response message
  typedef struct packed {
    logic [IMUL_WIDTH-1:0] result;
  } imul_resp_t;

  // Control unit to datapath
  typedef struct packed {
    logic a_sel;
    logic b_sel;
    logic result_sel;
    logic add_sel;
    logic a_en;
    logic result_en;
  } imul_ctrl_t;

  // Datapath to control unit
  typedef struct packed {
    logic b_lsb;
    logic b_zero;
  } imul_status_t;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imul_state_e;

endpackage

`default_nettype wire
